// File: panel_cmd.f
+incdir+rtl
+incdir+verification
rtl/panel_pkg.sv
rtl/fill_area.sv
rtl/cmd_decoder.sv
rtl/cmd_fillpanel.sv
rtl/cmd_setpixel.sv
rtl/frame_buffer.sv
rtl/panel_cmd_top.sv
verification/tb_panel_cmd.sv

// File: rtl/cmd_decoder.sv
// ==========================================================
// Command decoder
// Takes opcodes and routes payload bytes to a command block
// ==========================================================
`default_nettype none

`include "panel_cfg.svh"

module cmd_decoder (
    input  wire                  clk,
    input  wire                  reset,
    input  wire logic [7:0]      in_data,
    input  wire                  in_valid,
    input  wire                  fill_done,
    input  wire                  pixel_done,
    output logic                 in_ready,
    output panel_pkg::cmd_port_t fill_port,
    output panel_pkg::cmd_port_t pixel_port,
    output logic                 busy
);
    import panel_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        PAYLOAD,
        WAIT
    } dec_state_t;

    // Longest payload is row, column and colour
    localparam int CNT_W = $clog2(`BYTES_PER_PIXEL + 3);

    dec_state_t       state;
    cmd_op_t          opcode;
    logic [CNT_W-1:0] byte_cnt;
    logic [CNT_W-1:0] last_cnt;
    logic             accept;
    logic             sel_done;
    logic             in_payload;

    assign in_ready   = (state != WAIT);
    assign busy       = (state == WAIT);
    assign accept     = in_valid && in_ready;
    assign in_payload = accept && (state == PAYLOAD);

    assign last_cnt = (opcode == OP_FILL_PANEL) ? CNT_W'(`BYTES_PER_PIXEL - 1)
                                                : CNT_W'(`BYTES_PER_PIXEL + 1);
    assign sel_done = (opcode == OP_FILL_PANEL) ? fill_done : pixel_done;

    // Payload goes out in the cycle it is accepted
    always_comb begin
        fill_port.valid  = in_payload && (opcode == OP_FILL_PANEL);
        fill_port.data   = in_data;
        pixel_port.valid = in_payload && (opcode == OP_SET_PIXEL);
        pixel_port.data  = in_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            opcode   <= OP_FILL_PANEL;
            byte_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // Unknown opcodes are simply dropped
                    if (accept && (in_data == 8'(OP_FILL_PANEL) ||
                                   in_data == 8'(OP_SET_PIXEL))) begin
                        opcode   <= cmd_op_t'(in_data);
                        byte_cnt <= '0;
                        state    <= PAYLOAD;
                    end
                end
                PAYLOAD: begin
                    if (accept) begin
                        if (byte_cnt == last_cnt) begin
                            state <= WAIT;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                WAIT: begin
                    if (sel_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // A command block only finishes after it was handed a command
    a_no_done_in_idle: assert property (@(posedge clk) disable iff (reset)
        (fill_done || pixel_done) |-> (state != IDLE))
        else $error("command done pulse while decoder idle");

endmodule

`default_nettype wire

// File: rtl/cmd_fillpanel.sv
// ==========================================================
// Fill panel command
// Captures a colour and fills the whole panel with it
// ==========================================================
`default_nettype none

`include "panel_cfg.svh"

module cmd_fillpanel (
    input  wire                  clk,
    input  wire                  reset,
    input  wire panel_pkg::cmd_port_t port,
    output panel_pkg::fb_write_t fb_wr,
    output logic                 done
);
    import panel_pkg::*;

    typedef enum logic [1:0] {
        CAPTURE,
        START,
        RUNNING,
        DONE
    } fill_state_t;

    localparam int CNT_W = $clog2(`BYTES_PER_PIXEL + 1);

    fill_state_t      state;
    logic [CNT_W-1:0] byte_cnt;
    color_t           color;
    logic             area_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= CAPTURE;
            byte_cnt <= '0;
            color    <= '0;
        end else begin
            case (state)
                CAPTURE: begin
                    if (port.valid) begin
                        // MSB first, so shift in from the bottom
                        color <= color_t'({color, port.data});
                        if (byte_cnt == CNT_W'(`BYTES_PER_PIXEL - 1)) begin
                            state <= START;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                START: state <= RUNNING;
                RUNNING: begin
                    if (area_done) begin
                        color <= '0;
                        state <= DONE;
                    end
                end
                DONE: begin
                    byte_cnt <= '0;
                    state    <= CAPTURE;
                end
                default: state <= CAPTURE;
            endcase
        end
    end

    assign done = (state == RUNNING) && area_done;

    fill_area u_fill_area (
        .clk    (clk),
        .reset  (reset),
        .start  (state == START),
        .x0     (col_addr_t'(0)),
        .y0     (row_addr_t'(0)),
        .width  (col_addr_t'(`PANEL_WIDTH)),
        .height (row_addr_t'(`PANEL_HEIGHT)),
        .color  (color),
        .fb_wr  (fb_wr),
        .done   (area_done)
    );

endmodule

`default_nettype wire

// File: rtl/cmd_setpixel.sv
// ==========================================================
// Set pixel command
// Captures coordinates and colour, writes one pixel
// ==========================================================
`default_nettype none

`include "panel_cfg.svh"

module cmd_setpixel (
    input  wire                  clk,
    input  wire                  reset,
    input  wire panel_pkg::cmd_port_t port,
    output panel_pkg::fb_write_t fb_wr,
    output logic                 done
);
    import panel_pkg::*;

    typedef enum logic [2:0] {
        ROW,
        COL,
        COLOR,
        WRITE,
        DONE
    } pix_state_t;

    localparam int CNT_W = $clog2(`BYTES_PER_PIXEL + 1);

    pix_state_t       state;
    logic [CNT_W-1:0] byte_cnt;
    logic [7:0]       row_byte;
    logic [7:0]       col_byte;
    color_t           color;
    logic             in_range;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ROW;
            byte_cnt <= '0;
        end else begin
            case (state)
                ROW: if (port.valid) state <= COL;
                COL: begin
                    if (port.valid) begin
                        byte_cnt <= '0;
                        state    <= COLOR;
                    end
                end
                COLOR: begin
                    if (port.valid) begin
                        if (byte_cnt == CNT_W'(`BYTES_PER_PIXEL - 1)) begin
                            state <= WRITE;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                WRITE: state <= DONE;
                DONE: state <= ROW;
                default: state <= ROW;
            endcase
        end
    end

    // Payload capture
    always_ff @(posedge clk) begin
        if (port.valid) begin
            if (state == ROW) row_byte <= port.data;
            if (state == COL) col_byte <= port.data;
            if (state == COLOR) color <= color_t'({color, port.data});
        end
    end

    // Off-panel coordinates are dropped silently
    assign in_range = (row_byte < `PANEL_HEIGHT) && (col_byte < `PANEL_WIDTH);

    always_comb begin
        fb_wr.valid = (state == WRITE) && in_range;
        fb_wr.row   = row_addr_t'(row_byte);
        fb_wr.col   = col_addr_t'(col_byte);
        fb_wr.color = color;
    end

    assign done = (state == DONE);

endmodule

`default_nettype wire

// File: rtl/fill_area.sv
// ==========================================================
// Rectangle fill engine
// Sweeps an area row by row, one pixel write per cycle
// ==========================================================
`default_nettype none

module fill_area (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   start,
    input  wire panel_pkg::col_addr_t x0,
    input  wire panel_pkg::row_addr_t y0,
    input  wire panel_pkg::col_addr_t width,
    input  wire panel_pkg::row_addr_t height,
    input  wire panel_pkg::color_t    color,
    output panel_pkg::fb_write_t  fb_wr,
    output logic                  done
);
    import panel_pkg::*;

    logic      running;
    row_addr_t row_cnt;
    col_addr_t col_cnt;
    logic      last_col;
    logic      last_row;

    assign last_col = (col_cnt == col_addr_t'(width - 1'b1));
    assign last_row = (row_cnt == row_addr_t'(height - 1'b1));

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            done    <= 1'b0;
            row_cnt <= '0;
            col_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                row_cnt <= '0;
                col_cnt <= '0;
            end else if (running) begin
                if (last_col) begin
                    col_cnt <= '0;
                    if (last_row) begin
                        running <= 1'b0;
                        done    <= 1'b1;
                    end else begin
                        row_cnt <= row_cnt + 1'b1;
                    end
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end
        end
    end

    always_comb begin
        fb_wr.valid = running;
        fb_wr.row   = row_addr_t'(y0 + row_cnt);
        fb_wr.col   = col_addr_t'(x0 + col_cnt);
        fb_wr.color = color;
    end

    // A new sweep must wait for the current one to finish
    a_no_restart: assert property (@(posedge clk) disable iff (reset)
        start |-> !running)
        else $error("fill engine started while sweeping");

endmodule

`default_nettype wire

// File: rtl/frame_buffer.sv
// ==========================================================
// Frame buffer
// Pixel RAM with two merged write streams and one read port
// ==========================================================
`default_nettype none

`include "panel_cfg.svh"

module frame_buffer (
    input  wire                   clk,
    input  wire panel_pkg::fb_write_t fill_wr,
    input  wire panel_pkg::fb_write_t pixel_wr,
    input  wire panel_pkg::row_addr_t rd_row,
    input  wire panel_pkg::col_addr_t rd_col,
    output panel_pkg::color_t     rd_color
);
    import panel_pkg::*;

    localparam int DEPTH  = `PANEL_HEIGHT * `PANEL_WIDTH;
    localparam int ADDR_W = $clog2(DEPTH);

    color_t          mem [DEPTH];
    fb_write_t       wr;
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;

    // Row-major pixel index
    function automatic logic [ADDR_W-1:0] pix_addr(input row_addr_t row,
                                                   input col_addr_t col);
        return ADDR_W'(int'(row) * `PANEL_WIDTH + int'(col));
    endfunction

    // Only one command draws at a time
    assign wr      = fill_wr.valid ? fill_wr : pixel_wr;
    assign wr_addr = pix_addr(wr.row, wr.col);
    assign rd_addr = pix_addr(rd_row, rd_col);

    always_ff @(posedge clk) begin
        if (wr.valid) begin
            mem[wr_addr] <= wr.color;
        end
        rd_color <= mem[rd_addr];
    end

    // Both command blocks writing together would lose a pixel
    a_single_writer: assert property (@(posedge clk)
        !(fill_wr.valid && pixel_wr.valid))
        else $error("fill and set-pixel writes in the same cycle");

endmodule

`default_nettype wire

// File: rtl/panel_cfg.svh
// ==========================================================
// Panel configuration
// Panel geometry and colour depth for the command path
// ==========================================================
`ifndef PANEL_CFG_SVH
`define PANEL_CFG_SVH

// Number of columns
`define PANEL_WIDTH 16

// Number of rows
`define PANEL_HEIGHT 8

// Colour bytes per pixel, sent most significant first
`define BYTES_PER_PIXEL 2

`endif

// File: rtl/panel_cmd_top.sv
// ==========================================================
// Panel command path top level
// ==========================================================
`default_nettype none

module panel_cmd_top (
    input  wire                   clk,
    input  wire                   reset,
    input  wire logic [7:0]       in_data,
    input  wire                   in_valid,
    input  wire panel_pkg::row_addr_t rd_row,
    input  wire panel_pkg::col_addr_t rd_col,
    output logic                  in_ready,
    output logic                  busy,
    output logic                  cmd_done,
    output panel_pkg::color_t     rd_color
);
    import panel_pkg::*;

    cmd_port_t fill_port;
    cmd_port_t pixel_port;
    fb_write_t fill_wr;
    fb_write_t pixel_wr;
    logic      fill_done;
    logic      pixel_done;

    assign cmd_done = fill_done | pixel_done;

    cmd_decoder u_decoder (
        .clk        (clk),
        .reset      (reset),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .fill_done  (fill_done),
        .pixel_done (pixel_done),
        .in_ready   (in_ready),
        .fill_port  (fill_port),
        .pixel_port (pixel_port),
        .busy       (busy)
    );

    cmd_fillpanel u_fillpanel (
        .clk   (clk),
        .reset (reset),
        .port  (fill_port),
        .fb_wr (fill_wr),
        .done  (fill_done)
    );

    cmd_setpixel u_setpixel (
        .clk   (clk),
        .reset (reset),
        .port  (pixel_port),
        .fb_wr (pixel_wr),
        .done  (pixel_done)
    );

    frame_buffer u_frame_buffer (
        .clk      (clk),
        .fill_wr  (fill_wr),
        .pixel_wr (pixel_wr),
        .rd_row   (rd_row),
        .rd_col   (rd_col),
        .rd_color (rd_color)
    );

endmodule

`default_nettype wire

// File: rtl/panel_pkg.sv
// ==========================================================
// Panel command types
// Addresses, colours, opcodes and write requests
// ==========================================================
`default_nettype none

`include "panel_cfg.svh"

package panel_pkg;

    // Wide enough to hold the panel size itself, for bounds checks
    localparam int ROW_W = $clog2(`PANEL_HEIGHT + 1);
    localparam int COL_W = $clog2(`PANEL_WIDTH + 1);
    localparam int COLOR_W = `BYTES_PER_PIXEL * 8;

    typedef logic [ROW_W-1:0] row_addr_t;
    typedef logic [COL_W-1:0] col_addr_t;
    typedef logic [COLOR_W-1:0] color_t;

    typedef enum logic [7:0] {
        OP_FILL_PANEL = 8'h01,
        OP_SET_PIXEL  = 8'h02
    } cmd_op_t;

    // One frame-buffer write request
    typedef struct packed {
        logic      valid;
        row_addr_t row;
        col_addr_t col;
        color_t    color;
    } fb_write_t;

    // One payload byte toward a command block
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } cmd_port_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the panel command path testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f panel_cmd.f --top-module tb_panel_cmd \
    -Mdir obj_dir -o sim_panel_cmd

./obj_dir/sim_panel_cmd | tee sim.log

if grep -qx "all tests passed" sim.log; then
    exit 0
else
    exit 1
fi

// File: verification/panel_model.svh
// ==========================================================
// Frame buffer reference model
// Model pixel array, host byte sender and frame readback
// ==========================================================
`ifndef PANEL_MODEL_SVH
`define PANEL_MODEL_SVH

localparam int NUM_PIXELS = `PANEL_HEIGHT * `PANEL_WIDTH;
localparam int DONE_LIMIT = NUM_PIXELS + 20;

color_t model_mem [NUM_PIXELS];

// Offers one byte after a random idle gap and holds it until taken
task automatic send_byte(input logic [7:0] b);
    int gap;
    gap = $unsigned($random(seed)) % (max_gap + 1);
    repeat (gap) begin
        @(negedge clk);
        in_valid = 1'b0;
    end
    @(negedge clk);
    in_valid = 1'b1;
    in_data  = b;
    // in_ready only follows the decoder state, so it is settled here
    while (in_ready !== 1'b1) begin
        @(negedge clk);
    end
endtask

task automatic send_fill(input color_t color);
    send_byte(8'(OP_FILL_PANEL));
    for (int i = `BYTES_PER_PIXEL - 1; i >= 0; i--) begin
        send_byte(color[i*8 +: 8]);
    end
    for (int p = 0; p < NUM_PIXELS; p++) begin
        model_mem[p] = color;
    end
endtask

task automatic send_pixel(input logic [7:0] row, input logic [7:0] col, input color_t color);
    send_byte(8'(OP_SET_PIXEL));
    send_byte(row);
    send_byte(col);
    for (int i = `BYTES_PER_PIXEL - 1; i >= 0; i--) begin
        send_byte(color[i*8 +: 8]);
    end
    // Off-panel pixels leave the frame untouched
    if (row < `PANEL_HEIGHT && col < `PANEL_WIDTH) begin
        model_mem[int'(row) * `PANEL_WIDTH + int'(col)] = color;
    end
endtask

task automatic wait_cmd_done();
    int cycles;
    cycles = 0;
    @(negedge clk);
    in_valid = 1'b0;
    while (cmd_done !== 1'b1 && cycles < DONE_LIMIT) begin
        @(negedge clk);
        cycles++;
    end
    if (cmd_done !== 1'b1) begin
        $display("no cmd_done pulse within %0d cycles of the last byte", DONE_LIMIT);
        errors++;
    end
endtask

task automatic check_frame();
    for (int r = 0; r < `PANEL_HEIGHT; r++) begin
        for (int c = 0; c < `PANEL_WIDTH; c++) begin
            @(negedge clk);
            in_valid = 1'b0;
            rd_row   = row_addr_t'(r);
            rd_col   = col_addr_t'(c);
            // Registered read, data is there one cycle later
            @(negedge clk);
            checks++;
            if (rd_color !== model_mem[r * `PANEL_WIDTH + c]) begin
                $display("ERR rd_color row %h col %h expected %h got %h",
                         r, c, model_mem[r * `PANEL_WIDTH + c], rd_color);
                errors++;
            end
        end
    end
endtask

`endif

// File: verification/tb_panel_cmd.sv
// ==========================================================
// Panel command path testbench
// Seeded random commands checked against a frame model
// ==========================================================
`default_nettype none

`include "panel_cfg.svh"

module tb_panel_cmd;
    timeunit 1ns;
    timeprecision 100ps;
    import panel_pkg::*;

    localparam int NUM_SET      = 40;
    localparam int NUM_OOR      = 8;
    localparam int NUM_UNKNOWN  = 6;
    localparam int NUM_CMDS     = NUM_SET + NUM_OOR + 4;
    localparam int LIMIT_CYCLES = 2 * NUM_CMDS * (`PANEL_HEIGHT * `PANEL_WIDTH + 20);

    logic       clk;
    logic       reset;
    logic [7:0] in_data;
    logic       in_valid;
    row_addr_t  rd_row;
    col_addr_t  rd_col;
    logic       in_ready;
    logic       busy;
    logic       cmd_done;
    color_t     rd_color;

    integer seed        = 75;
    int     max_gap     = 3;
    int     errors      = 0;
    int     checks      = 0;
    int     tests       = 0;
    int     done_count  = 0;
    int     busy_cycles = 0;

    `include "panel_model.svh"

    panel_cmd_top UUT (
        .clk      (clk),
        .reset    (reset),
        .in_data  (in_data),
        .in_valid (in_valid),
        .rd_row   (rd_row),
        .rd_col   (rd_col),
        .in_ready (in_ready),
        .busy     (busy),
        .cmd_done (cmd_done),
        .rd_color (rd_color)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ==========================================================
    // Monitors
    // ==========================================================
    always @(negedge clk) begin
        if (!reset && cmd_done === 1'b1) done_count++;
        if (!reset && busy === 1'b1) begin
            busy_cycles++;
            if (in_ready !== 1'b0) begin
                $display("ERR in_ready expected %h got %h while busy", 1'b0, in_ready);
                errors++;
            end
        end
    end

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        $display("timeout: run still going after %0d cycles", LIMIT_CYCLES);
        $display("tests failed");
        $finish;
    end

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests++;
        if (errors == start_errors) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - start_errors);
    endtask

    // ==========================================================
    // Test sequence
    // ==========================================================
    initial begin
        logic [7:0] row;
        logic [7:0] col;
        logic [7:0] b;
        int         start_errors;
        int         done_before;
        int         busy_before;

        reset    = 1'b1;
        in_valid = 1'b0;
        in_data  = 8'h00;
        rd_row   = '0;
        rd_col   = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        start_errors = errors;
        checks += 3;
        if (in_ready !== 1'b1) begin
            $display("ERR in_ready expected %h got %h", 1'b1, in_ready);
            errors++;
        end
        if (busy !== 1'b0) begin
            $display("ERR busy expected %h got %h", 1'b0, busy);
            errors++;
        end
        if (cmd_done !== 1'b0) begin
            $display("ERR cmd_done expected %h got %h", 1'b0, cmd_done);
            errors++;
        end
        report_test("reset", start_errors);

        start_errors = errors;
        send_fill(color_t'($random(seed)));
        wait_cmd_done();
        check_frame();
        report_test("fill_panel", start_errors);

        start_errors = errors;
        for (int i = 0; i < NUM_SET; i++) begin
            row = 8'($unsigned($random(seed)) % `PANEL_HEIGHT);
            col = 8'($unsigned($random(seed)) % `PANEL_WIDTH);
            send_pixel(row, col, color_t'($random(seed)));
            wait_cmd_done();
        end
        check_frame();
        report_test("set_pixel", start_errors);

        start_errors = errors;
        for (int i = 0; i < NUM_OOR; i++) begin
            row = 8'($random(seed));
            col = 8'($random(seed));
            if (i % 2 == 0) row[7] = 1'b1;
            else col[7] = 1'b1;
            // First two sit just past the panel edge
            if (i == 0) row = 8'(`PANEL_HEIGHT);
            if (i == 1) col = 8'(`PANEL_WIDTH);
            send_pixel(row, col, color_t'($random(seed)));
            wait_cmd_done();
        end
        check_frame();
        report_test("out_of_range", start_errors);

        start_errors = errors;
        idle_cycles(2);
        done_before = done_count;
        for (int i = 0; i < NUM_UNKNOWN; i++) begin
            b = 8'($random(seed));
            while (b == 8'(OP_FILL_PANEL) || b == 8'(OP_SET_PIXEL)) begin
                b = 8'($random(seed));
            end
            send_byte(b);
        end
        row = 8'($unsigned($random(seed)) % `PANEL_HEIGHT);
        col = 8'($unsigned($random(seed)) % `PANEL_WIDTH);
        send_pixel(row, col, color_t'($random(seed)));
        wait_cmd_done();
        idle_cycles(4);
        checks++;
        if (done_count - done_before != 1) begin
            $display("expected one cmd_done after unknown opcodes, saw %0d",
                     done_count - done_before);
            errors++;
        end
        check_frame();
        report_test("unknown_opcode", start_errors);

        // Set pixel is offered while the fill still holds the decoder
        start_errors = errors;
        max_gap     = 6;
        busy_before = busy_cycles;
        done_before = done_count;
        send_fill(color_t'($random(seed)));
        row = 8'($unsigned($random(seed)) % `PANEL_HEIGHT);
        col = 8'($unsigned($random(seed)) % `PANEL_WIDTH);
        send_pixel(row, col, color_t'($random(seed)));
        wait_cmd_done();
        idle_cycles(4);
        max_gap = 3;
        checks += 2;
        if (busy_cycles - busy_before < NUM_PIXELS) begin
            $display("busy was high for only %0d cycles during the fill",
                     busy_cycles - busy_before);
            errors++;
        end
        if (done_count - done_before != 2) begin
            $display("expected two cmd_done pulses, saw %0d", done_count - done_before);
            errors++;
        end
        check_frame();
        report_test("back_pressure", start_errors);

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
